// File: fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define FETCH_PC_INIT 32'h0000_0000 // First fetch after reset.

`define L1I_LINES 4
`define L1I_WORDS 2 // Refill FSM assumes two.

`define ROM_DEPTH 24 // Words in prog.hex.

`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_SYSTEM   7'b1110011
`define OP_MISC_MEM 7'b0001111

`define FUNCT3_FENCE_I 3'b001

`endif

// File: fetch_pkg.sv
package fetch_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_fields_t;

  // Same word, seen whole or split into R-type fields.
  typedef union packed {
    logic [31:0]  raw;
    inst_fields_t fields;
  } inst_u;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr; // Byte address, word aligned.
  } mem_req_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] data;
  } mem_resp_t;

  typedef struct packed {
    logic [31:0] pc;
    inst_u       inst;
  } fetch_out_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

endpackage

// File: inst_rom.sv
`include "fetch_cfg.svh"

module inst_rom (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::mem_req_t  req_i,
  output fetch_pkg::mem_resp_t resp_o
);

  localparam int AW = $clog2(`ROM_DEPTH);

  logic [31:0] mem [`ROM_DEPTH];
  logic [29:0] word_addr;
  logic        in_range;
  logic        rvalid_q;
  logic [31:0] data_q;

  initial
  begin
    $readmemh("prog.hex", mem);
  end

  assign word_addr = req_i.addr[31:2];
  assign in_range  = word_addr < 30'(`ROM_DEPTH); // Reads past the end return zero.

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= req_i.valid;
  end

  always_ff @(posedge clk)
  begin
    if (req_i.valid)
      data_q <= in_range ? mem[word_addr[AW-1:0]] : 32'h0;
  end

  assign resp_o = '{rvalid: rvalid_q, data: data_q};

endmodule

// File: l1i_cache.sv
`include "fetch_cfg.svh"

module l1i_cache (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lookup_i,
  input  logic [31:0]          pc_i,
  input  logic                 fire_i,
  output logic                 hit_o,
  output fetch_pkg::inst_u     inst_o,
  output fetch_pkg::mem_req_t  req_o,
  input  fetch_pkg::mem_resp_t resp_i
);

  localparam int OFF_W = $clog2(`L1I_WORDS);
  localparam int IDX_W = $clog2(`L1I_LINES);
  localparam int LSB_W = OFF_W + 2; // Word offset plus byte offset.
  localparam int TAG_W = 32 - IDX_W - LSB_W;

  localparam logic [1:0] IDLE  = 2'd0;
  localparam logic [1:0] WAIT0 = 2'd1;
  localparam logic [1:0] REQ1  = 2'd2;
  localparam logic [1:0] WAIT1 = 2'd3;

  logic [1:0]            state_q;
  logic                  req_valid_q;
  logic [31:0]           req_addr_q;
  logic [`L1I_LINES-1:0] valid_q;
  logic [TAG_W-1:0]      tag_q [`L1I_LINES];
  fetch_pkg::inst_u      data_q [`L1I_LINES][`L1I_WORDS];

  logic [TAG_W-1:0] pc_tag;
  logic [IDX_W-1:0] pc_idx;
  logic [OFF_W-1:0] pc_off;
  logic [TAG_W-1:0] fill_tag;
  logic [IDX_W-1:0] fill_idx;
  logic             miss;
  logic             fill0;
  logic             fill1;
  logic             fence_i;

  assign pc_tag = pc_i[31 -: TAG_W];
  assign pc_idx = pc_i[LSB_W +: IDX_W];
  assign pc_off = pc_i[2 +: OFF_W];

  // Line under refill, taken from the address in flight.
  assign fill_tag = req_addr_q[31 -: TAG_W];
  assign fill_idx = req_addr_q[LSB_W +: IDX_W];

  assign hit_o  = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign inst_o = data_q[pc_idx][pc_off];
  assign req_o  = '{valid: req_valid_q, addr: req_addr_q};

  assign miss  = (state_q == IDLE) && lookup_i && !hit_o;
  assign fill0 = (state_q == WAIT0) && resp_i.rvalid;
  assign fill1 = (state_q == WAIT1) && resp_i.rvalid;

  assign fence_i = fire_i &&
                   (inst_o.fields.opcode == `OP_MISC_MEM) &&
                   (inst_o.fields.funct3 == `FUNCT3_FENCE_I);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= IDLE;
      req_valid_q <= 1'b0;
      valid_q     <= '0;
    end
    else
    begin
      req_valid_q <= 1'b0; // One-cycle request strobe.
      case (state_q)
        IDLE:
          if (miss)
          begin
            req_valid_q     <= 1'b1;
            valid_q[pc_idx] <= 1'b0; // Old line is being overwritten.
            state_q         <= WAIT0;
          end
        WAIT0:
          if (fill0)
          begin
            req_valid_q <= 1'b1;
            state_q     <= REQ1;
          end
        REQ1:
          state_q <= WAIT1;
        WAIT1:
          if (fill1)
          begin
            valid_q[fill_idx] <= 1'b1;
            state_q           <= IDLE;
          end
        default:
          state_q <= IDLE;
      endcase
      if (fence_i)
        valid_q <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (miss)
      req_addr_q <= {pc_i[31:LSB_W], {LSB_W{1'b0}}}; // Even word first.
    else if (fill0)
      req_addr_q <= req_addr_q + 32'd4;
    if (fill0)
      data_q[fill_idx][0] <= resp_i.data;
    if (fill1)
    begin
      data_q[fill_idx][1] <= resp_i.data;
      tag_q[fill_idx]     <= fill_tag;
    end
  end

endmodule

// File: fetch_ctrl.sv
`include "fetch_cfg.svh"

module fetch_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hit_i,
  input  fetch_pkg::inst_u     inst_i,
  input  logic                 ready_i,
  input  fetch_pkg::redirect_t redirect_i,
  output logic                 lookup_o,
  output logic [31:0]          pc_o,
  output logic                 fire_o
);

  logic        lookup_q;
  logic [31:0] pc_q;
  logic [6:0]  opcode;
  logic        is_cf;

  assign opcode = inst_i.fields.opcode;

  // Anything that may leave the sequential path.
  assign is_cf = (opcode == `OP_JAL)    ||
                 (opcode == `OP_JALR)   ||
                 (opcode == `OP_BRANCH) ||
                 (opcode == `OP_SYSTEM);

  assign fire_o = lookup_q && hit_i && ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q     <= `FETCH_PC_INIT;
      lookup_q <= 1'b1;
    end
    else if (!lookup_q)
    begin
      if (redirect_i.valid) // Parked until execute resolves the target.
      begin
        pc_q     <= redirect_i.pc;
        lookup_q <= 1'b1;
      end
    end
    else if (fire_o)
    begin
      if (is_cf)
        lookup_q <= 1'b0;
      else
        pc_q <= pc_q + 32'd4;
    end
  end

  assign lookup_o = lookup_q;
  assign pc_o     = pc_q;

endmodule

// File: fetch_top.sv
module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::redirect_t  redirect_i,
  input  logic                  ready_i,
  output logic                  valid_o,
  output fetch_pkg::fetch_out_t out_o
);

  logic                 lookup;
  logic                 hit;
  logic                 fire;
  logic [31:0]          pc;
  fetch_pkg::inst_u     inst;
  fetch_pkg::mem_req_t  mem_req;
  fetch_pkg::mem_resp_t mem_resp;

  fetch_ctrl ctrl0 (
    .clk        (clk),
    .rst        (rst),
    .hit_i      (hit),
    .inst_i     (inst),
    .ready_i    (ready_i),
    .redirect_i (redirect_i),
    .lookup_o   (lookup),
    .pc_o       (pc),
    .fire_o     (fire)
  );

  l1i_cache cache0 (
    .clk      (clk),
    .rst      (rst),
    .lookup_i (lookup),
    .pc_i     (pc),
    .fire_i   (fire),
    .hit_o    (hit),
    .inst_o   (inst),
    .req_o    (mem_req),
    .resp_i   (mem_resp)
  );

  inst_rom rom0 (
    .clk    (clk),
    .rst    (rst),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

  assign valid_o = lookup & hit;
  assign out_o   = '{pc: pc, inst: inst};

endmodule

// File: fetch_top_chk.sv
module fetch_top_chk (
  input logic                  clk,
  input logic                  rst,
  input logic                  ready_i,
  input logic                  valid_i,
  input fetch_pkg::fetch_out_t out_i,
  input fetch_pkg::mem_req_t   mem_req_i,
  input fetch_pkg::mem_resp_t  mem_resp_i
);

  int unsigned fail_count = 0;

  hold_out: assert property (@(posedge clk) disable iff (rst)
    valid_i && !ready_i |=> $stable(out_i))
    else
    begin
      $error("out_o changed while valid_o waited for ready_i.");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk) rst |=> !valid_i)
    else
    begin
      $error("valid_o high after a reset edge.");
      fail_count++;
    end

  // ROM answers next cycle, so the bus is busy for exactly one.
  one_in_flight: assert property (@(posedge clk) disable iff (rst)
    mem_req_i.valid |=> !mem_req_i.valid && mem_resp_i.rvalid)
    else
    begin
      $error("Memory request issued while a response was pending.");
      fail_count++;
    end

endmodule

bind fetch_top fetch_top_chk chk0 (
  .clk        (clk),
  .rst        (rst),
  .ready_i    (ready_i),
  .valid_i    (valid_o),
  .out_i      (out_o),
  .mem_req_i  (mem_req),
  .mem_resp_i (mem_resp)
);

// File: tb_fetch_top.sv
`include "fetch_cfg.svh"

module tb_fetch_top;

  localparam int TOTAL_XFERS     = 49; // Transfers over all six tests.
  localparam int WATCHDOG_CYCLES = TOTAL_XFERS * 20;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  ready_i;
  logic                  valid_o;
  fetch_pkg::redirect_t  redirect_i;
  fetch_pkg::fetch_out_t out_o;

  logic [31:0] rom_img [`ROM_DEPTH];
  logic [31:0] model_pc;
  logic        model_stopped;
  logic [31:0] first_pc;
  int          xfer_count = 0;
  int          errors = 0;
  int          tests_failed = 0;
  int          test_errors_at = 0;

  fetch_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .redirect_i (redirect_i),
    .ready_i    (ready_i),
    .valid_o    (valid_o),
    .out_o      (out_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] expect_inst(input logic [31:0] pc);
    if (pc[31:2] < `ROM_DEPTH)
      return rom_img[pc[31:2]];
    return 32'h0; // Reads past the end give zero.
  endfunction

  function automatic bit ends_fetch(input logic [31:0] inst);
    case (inst[6:0])
      `OP_JAL, `OP_JALR, `OP_BRANCH, `OP_SYSTEM:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic close_test(input int num, input string name);
    int errs;
    errs = errors - test_errors_at;
    if (errs != 0)
      tests_failed++;
    $display("Test %0d %s: %s, %0d errors, %0d transfers so far", num, name,
             (errs == 0) ? "ok" : "failed", errs, xfer_count);
    test_errors_at = errors;
  endtask

  task automatic redirect_to(input logic [31:0] target);
    int delay;
    delay = $urandom % 6;
    repeat (delay)
    begin
      @(negedge clk);
      ready_i = 1'($urandom % 2);
    end
    @(negedge clk);
    redirect_i = '{valid: 1'b1, pc: target};
    @(negedge clk);
    redirect_i = '{valid: 1'b0, pc: 32'h0};
  endtask

  task automatic run_to_stop(input bit stall, input int exp_xfers);
    int start;
    start = xfer_count;
    while (!model_stopped)
    begin
      ready_i = stall ? ($urandom % 3 != 0) : 1'b1;
      @(negedge clk);
    end
    assert (xfer_count - start == exp_xfers)
    else report_mismatch("transfer count", exp_xfers, xfer_count - start);
  endtask

  always @(posedge clk)
  begin : compare
    logic [31:0] exp_inst;
    if (rst)
    begin
      model_pc      = `FETCH_PC_INIT;
      model_stopped = 1'b0;
    end
    else if (model_stopped)
    begin
      assert (!valid_o) else report_mismatch("valid_o", 32'h0, valid_o);
      if (redirect_i.valid)
      begin
        model_pc      = redirect_i.pc;
        model_stopped = 1'b0;
      end
    end
    else if (valid_o && ready_i)
    begin
      exp_inst = expect_inst(model_pc);
      assert (out_o.pc == model_pc) else report_mismatch("out_o.pc", model_pc, out_o.pc);
      assert (out_o.inst.raw == exp_inst)
      else report_mismatch("out_o.inst", exp_inst, out_o.inst.raw);
      if (xfer_count == 0)
        first_pc = out_o.pc;
      xfer_count++;
      if (ends_fetch(exp_inst))
        model_stopped = 1'b1; // Wait for execute.
      else
        model_pc = model_pc + 32'd4;
    end
  end

  initial
  begin
    void'($urandom(86859));
    $readmemh("prog.hex", rom_img);
    rst        = 1'b1;
    ready_i    = 1'b0;
    redirect_i = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst     = 1'b0;
    ready_i = 1'b1;
    assert (valid_o == 1'b0) else report_mismatch("valid_o", 32'h0, valid_o);
    while (xfer_count == 0)
      @(negedge clk);
    assert (first_pc == `FETCH_PC_INIT)
    else report_mismatch("first out_o.pc", `FETCH_PC_INIT, first_pc);
    close_test(1, "reset");
    run_to_stop(1'b0, 7); // Words 1 to 7, ends on the branch.
    close_test(2, "straight-line fetch");
    redirect_to(32'd32);
    run_to_stop(1'b0, 3); // JAL.
    redirect_to(32'd80);
    run_to_stop(1'b0, 1); // ECALL.
    redirect_to(32'd60);
    run_to_stop(1'b0, 1); // JALR.
    close_test(3, "stop on control flow");
    redirect_to(32'd64);
    run_to_stop(1'b1, 5);
    redirect_to(32'd84);
    run_to_stop(1'b1, 2);
    close_test(4, "back-pressure");
    redirect_to(32'd0); // Lines were replaced by words 16 to 22.
    run_to_stop(1'b1, 8);
    redirect_to(32'd16);
    run_to_stop(1'b0, 4);
    close_test(5, "refetch after backward redirect");
    redirect_to(32'd44);
    run_to_stop(1'b0, 5);
    redirect_to(32'd0);
    run_to_stop(1'b1, 8);
    redirect_to(32'd48);
    run_to_stop(1'b1, 4);
    close_test(6, "FENCE.I flush");
    assert (xfer_count == TOTAL_XFERS)
    else report_mismatch("total transfers", TOTAL_XFERS, xfer_count);
    $display("Tests run: 6, failed: %0d, transfers: %0d, errors: %0d, assertion fails: %0d",
             tests_failed, xfer_count, errors, dut0.chk0.fail_count);
    if (errors == 0 && dut0.chk0.fail_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: fetch_top.f
+incdir+.
fetch_pkg.sv
inst_rom.sv
l1i_cache.sv
fetch_ctrl.sv
fetch_top.sv
fetch_top_chk.sv
tb_fetch_top.sv

// File: prog.hex
// One 32-bit instruction word per line, word address 0 first.
00100093
00200113
00300193
00208233
401182b3
0020c333
0020e3b3
00208463
0020f433
00209493
0080006f
12345537
0000100f
00b00593
00c00613
00008067
00000697
00e00713
0ff0000f
00f00793
00000073
01000813
00100073
00000013
